// ==== flist.f ====
verilog/tcb_pkg.sv
verilog/tcb_if.sv
verilog/tcb_arb.sv
verilog/tcb_mem.sv
verilog/tcb_top.sv
verif/tcb_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the tcb testbench with verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tcb_tb \
  -f flist.f -o tcb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/tcb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints the fail line on any error or timeout
if grep -q '\*\*\* FAILED \*\*\*' "$SIM_LOG"; then
  exit 1
fi
exit 0

// ==== verif/tcb_tb.sv ====
`timescale 1ns/1ps

module tcb_tb
  import tcb_pkg::*;
();

  // random mix length
  localparam int N_RAND = 200;
  // all transfers of the run for the watchdog
  localparam int N_XFER = MEM_DEPTH + 31 + N_RAND;

  logic              bus = 1'b0;
  logic              reset;
  logic              m0_vld, m0_wen, m0_rdy, m0_err;
  logic [TCB_AW-1:0] m0_adr;
  logic [TCB_BW-1:0] m0_ben;
  logic [TCB_DW-1:0] m0_wdt, m0_rdt;
  logic              m1_vld, m1_wen, m1_rdy, m1_err;
  logic [TCB_AW-1:0] m1_adr;
  logic [TCB_BW-1:0] m1_ben;
  logic [TCB_DW-1:0] m1_wdt, m1_rdt;

  // one expected response due when cyc reaches due
  typedef struct {
    string             name;
    logic              rd;
    logic [TCB_DW-1:0] rdt;
    logic              err;
    int                due;
  } exp_t;

  logic [TCB_DW-1:0] model [MEM_DEPTH];
  exp_t              exp0_q [$];
  exp_t              exp1_q [$];
  // served manager per transfer in transfer order
  int                order_q [$];
  int                cyc = 0;
  int                errors = 0;
  int                checks = 0;
  int                seed = 88;

  // random mix drawn before the managers start
  logic              r_wen [N_RAND];
  logic              r_gap [N_RAND];
  logic [TCB_AW-1:0] r_adr [N_RAND];
  logic [TCB_BW-1:0] r_ben [N_RAND];
  logic [TCB_DW-1:0] r_wdt [N_RAND];

  tcb_top DUT (.*);

  always #4 bus = ~bus;

  always @(posedge bus) cyc <= cyc + 1;

  //////////////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////////////

  // byte merge under ben
  // err and no effect at or above 4*MEM_DEPTH
  function automatic void ref_access(input logic wen, input logic [TCB_AW-1:0] adr,
                                     input logic [TCB_BW-1:0] ben,
                                     input logic [TCB_DW-1:0] wdt,
                                     output logic [TCB_DW-1:0] rdt, output logic err);
    int unsigned w;
    err = (adr >= 4 * MEM_DEPTH);
    rdt = '0;
    w   = adr / 4;
    if (!err && wen) begin
      for (int b = 0; b < TCB_BW; b++) begin
        if (ben[b]) model[w][8*b +: 8] = wdt[8*b +: 8];
      end
    end else if (!err) begin
      rdt = model[w];
    end
  endfunction

  // fill value mixing every address bit
  function automatic logic [TCB_DW-1:0] fill_word(input logic [TCB_AW-1:0] adr);
    return (adr * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
  endfunction

  // queues the prediction at the transfer edge
  function automatic void log_xfer(input int m, input string name, input logic wen,
                                   input logic [TCB_AW-1:0] adr,
                                   input logic [TCB_BW-1:0] ben,
                                   input logic [TCB_DW-1:0] wdt);
    exp_t e;
    e.name = name;
    e.rd   = !wen;
    e.due  = cyc + TCB_DLY - 1;
    ref_access(wen, adr, ben, wdt, e.rdt, e.err);
    order_q.push_back(m);
    if (m == 0) exp0_q.push_back(e);
    else exp1_q.push_back(e);
  endfunction

  //////////////////////////////////////////////////////////////////////////////
  // manager tasks
  //////////////////////////////////////////////////////////////////////////////

  // starts 1 ns after an edge and returns 1 ns after the transfer edge
  task automatic m0_access(input string name, input logic wen, input logic [TCB_AW-1:0] adr,
                           input logic [TCB_BW-1:0] ben, input logic [TCB_DW-1:0] wdt);
    m0_vld = 1'b1;
    m0_wen = wen;
    m0_adr = adr;
    m0_ben = ben;
    m0_wdt = wdt;
    // rdy is settled mid cycle
    @(negedge bus);
    while (!m0_rdy) @(negedge bus);
    @(posedge bus);
    #1;
    log_xfer(0, name, wen, adr, ben, wdt);
    m0_vld = 1'b0;
  endtask

  task automatic m1_access(input string name, input logic wen, input logic [TCB_AW-1:0] adr,
                           input logic [TCB_BW-1:0] ben, input logic [TCB_DW-1:0] wdt);
    m1_vld = 1'b1;
    m1_wen = wen;
    m1_adr = adr;
    m1_ben = ben;
    m1_wdt = wdt;
    @(negedge bus);
    while (!m1_rdy) @(negedge bus);
    @(posedge bus);
    #1;
    log_xfer(1, name, wen, adr, ben, wdt);
    m1_vld = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge bus);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // checker
  //////////////////////////////////////////////////////////////////////////////

  function automatic void compare(input exp_t e, input logic [TCB_DW-1:0] rdt, input logic err);
    checks++;
    if (err !== e.err) begin
      errors++;
      $display("Mismatch %s err: expected %0b actual %0b", e.name, e.err, err);
    end
    // write data on rdt is unspecified
    if (e.rd && rdt !== e.rdt) begin
      errors++;
      $display("Mismatch %s rdt: expected %h actual %h", e.name, e.rdt, rdt);
    end
  endfunction

  // responses are stable mid cycle
  always @(negedge bus) begin : check_rsp
    exp_t e;
    if (m0_rdy && m1_rdy) begin
      errors++;
      $display("Error: both managers see rdy in one cycle");
    end
    if (reset && (m0_rdy || m1_rdy)) begin
      errors++;
      $display("Error: rdy is high during reset");
    end
    if (exp0_q.size() > 0 && exp0_q[0].due == cyc) begin
      e = exp0_q.pop_front();
      compare(e, m0_rdt, m0_err);
    end else if (m0_err !== 1'b0) begin
      errors++;
      $display("Error: manager 0 sees err with no response due");
    end
    if (exp1_q.size() > 0 && exp1_q[0].due == cyc) begin
      e = exp1_q.pop_front();
      compare(e, m1_rdt, m1_err);
    end else if (m1_err !== 1'b0) begin
      errors++;
      $display("Error: manager 1 sees err with no response due");
    end
  end

  // 200 cycles of 8 ns per transfer
  initial begin : watchdog
    #(N_XFER * 200 * 8);
    $display("Error: run timed out after %0d cycles", cyc);
    $display("*** FAILED ***");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0] r;
    {m0_vld, m0_wen, m0_adr, m0_ben, m0_wdt} = '0;
    {m1_vld, m1_wen, m1_adr, m1_ben, m1_wdt} = '0;
    reset = 1'b1;
    for (int k = 0; k < N_RAND; k++) begin
      r        = $random(seed);
      r_wen[k] = r[0];
      r_gap[k] = (r[31:30] == 2'b00);
      r_adr[k] = r & (4 * MEM_DEPTH - 4);
      r_wdt[k] = $random(seed);
      r        = $random(seed);
      // a write needs at least one byte enable
      r_ben[k] = (r[3:0] == 4'b0) ? 4'b1111 : r[3:0];
    end
    repeat (8) @(posedge bus);
    #1;
    reset = 1'b0;
    // known contents everywhere
    for (int k = 0; k < MEM_DEPTH; k++) m0_access("fill", 1'b1, k * 4, 4'hf, fill_word(k * 4));
    // full word write and read back
    m0_access("wr_rd", 1'b1, 32'h40, 4'hf, 32'hdead_beef);
    m0_access("wr_rd", 1'b0, 32'h40, 4'h0, '0);
    // partial writes into one word
    m0_access("merge", 1'b1, 32'h80, 4'b0001, 32'h1111_11aa);
    m0_access("merge", 1'b0, 32'h80, 4'h0, '0);
    m0_access("merge", 1'b1, 32'h80, 4'b0110, 32'hbbcc_ddee);
    m0_access("merge", 1'b0, 32'h80, 4'h0, '0);
    m1_access("merge", 1'b1, 32'h80, 4'b1000, 32'h7722_3344);
    m1_access("merge", 1'b0, 32'h80, 4'h0, '0);
    m1_access("merge", 1'b1, 32'h80, 4'b0101, 32'h5566_7788);
    m1_access("merge", 1'b0, 32'h80, 4'h0, '0);
    // out of range accesses leave words 0 and 255 untouched
    m0_access("range", 1'b1, 4 * MEM_DEPTH, 4'hf, 32'h0bad_0bad);
    m0_access("range", 1'b0, 4 * MEM_DEPTH, 4'h0, '0);
    m1_access("range", 1'b1, 32'hffff_fffc, 4'hf, 32'h0bad_0bad);
    m1_access("range", 1'b0, 32'h0, 4'h0, '0);
    m1_access("range", 1'b0, 4 * MEM_DEPTH - 4, 4'h0, '0);
    // both managers back to back
    order_q.delete();
    fork
      for (int j = 0; j < 4; j++) begin
        m0_access("arb_alt", 1'b1, 32'h100 + 8 * j, 4'hf, 32'ha000_0000 + j);
        m0_access("arb_alt", 1'b0, 32'h100 + 8 * j, 4'h0, '0);
      end
      for (int j = 0; j < 4; j++) begin
        m1_access("arb_alt", 1'b1, 32'h104 + 8 * j, 4'hf, 32'hb000_0000 + j);
        m1_access("arb_alt", 1'b0, 32'h104 + 8 * j, 4'h0, '0);
      end
    join
    for (int j = 1; j < order_q.size(); j++) begin
      if (order_q[j] == order_q[j-1]) begin
        errors++;
        $display("Error: manager %0d was granted twice in a row", order_q[j]);
      end
    end
    // random mix with even ops on manager 0 and odd on manager 1
    fork
      for (int k = 0; k < N_RAND; k += 2) begin
        if (r_gap[k]) idle(1);
        m0_access("random", r_wen[k], r_adr[k], r_ben[k], r_wdt[k]);
      end
      for (int k = 1; k < N_RAND; k += 2) begin
        if (r_gap[k]) idle(1);
        m1_access("random", r_wen[k], r_adr[k], r_ben[k], r_wdt[k]);
      end
    join
    idle(TCB_DLY + 2);
    if (exp0_q.size() != 0 || exp1_q.size() != 0) begin
      errors++;
      $display("Error: some responses were never checked");
    end
    $display("errors: %0d checks: %0d", errors, checks);
    if (errors == 0 && checks > 0) $display("*** PASSED ***");
    else $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== verilog/tcb_top.sv ====
`timescale 1ns/1ps

module tcb_top
  import tcb_pkg::*;
(
  input  logic              bus,
  input  logic              reset,
  // manager 0
  input  logic              m0_vld,
  input  logic              m0_wen,
  input  logic [TCB_AW-1:0] m0_adr,
  input  logic [TCB_BW-1:0] m0_ben,
  input  logic [TCB_DW-1:0] m0_wdt,
  output logic              m0_rdy,
  output logic [TCB_DW-1:0] m0_rdt,
  output logic              m0_err,
  // manager 1
  input  logic              m1_vld,
  input  logic              m1_wen,
  input  logic [TCB_AW-1:0] m1_adr,
  input  logic [TCB_BW-1:0] m1_ben,
  input  logic [TCB_DW-1:0] m1_wdt,
  output logic              m1_rdy,
  output logic [TCB_DW-1:0] m1_rdt,
  output logic              m1_err
);

  ////////////////////////////////////////////////////////////////////////////
  // bus instances
  ////////////////////////////////////////////////////////////////////////////

  // manager side links into the arbiter
  tcb_if m0_if (.clk(bus), .reset(reset));
  tcb_if m1_if (.clk(bus), .reset(reset));
  // arbiter to memory
  tcb_if mem_if (.clk(bus), .reset(reset));

  // manager 0 request in, response out
  assign m0_if.vld = m0_vld;
  assign m0_if.wen = m0_wen;
  assign m0_if.adr = m0_adr;
  assign m0_if.ben = m0_ben;
  assign m0_if.wdt = m0_wdt;
  assign m0_rdy    = m0_if.rdy;
  assign m0_rdt    = m0_if.rdt;
  assign m0_err    = m0_if.err;

  // manager 1, same mapping
  assign m1_if.vld = m1_vld;
  assign m1_if.wen = m1_wen;
  assign m1_if.adr = m1_adr;
  assign m1_if.ben = m1_ben;
  assign m1_if.wdt = m1_wdt;
  assign m1_rdy    = m1_if.rdy;
  assign m1_rdt    = m1_if.rdt;
  assign m1_err    = m1_if.err;

  ////////////////////////////////////////////////////////////////////////////
  // arbiter and memory
  ////////////////////////////////////////////////////////////////////////////

  tcb_arb arb (
    .bus   (bus),
    .reset (reset),
    .man0  (m0_if),
    .man1  (m1_if),
    .sub   (mem_if)
  );

  tcb_mem mem (
    .bus (mem_if)
  );

endmodule

// ==== verilog/tcb_mem.sv ====
`timescale 1ns/1ps

module tcb_mem
  import tcb_pkg::*;
(
  tcb_if.sub bus
);

  ////////////////////////////////////////////////////////////////////////////
  // storage and address decode
  ////////////////////////////////////////////////////////////////////////////

  tcb_data_t mem [MEM_DEPTH];

  // write data in byte view
  tcb_data_t         wdt;
  // word index
  logic [MEM_AW-1:0] idx;
  // address below 4*MEM_DEPTH
  logic              in_rng;

  assign wdt    = bus.wdt;
  assign idx    = bus.adr[MEM_AW+1:2];
  assign in_rng = (bus.adr[TCB_AW-1:MEM_AW+2] == '0);

  // always ready once out of reset
  logic rdy;

  always_ff @(posedge bus.clk) begin
    if (bus.reset) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  assign bus.rdy = rdy;

  // byte merge under ben, out of range writes dropped
  always_ff @(posedge bus.clk) begin
    if (bus.trn && bus.wen && in_rng) begin
      for (int b = 0; b < TCB_BW; b++) begin
        if (bus.ben[b]) begin
          mem[idx].byt[b] <= wdt.byt[b];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response pipeline
  ////////////////////////////////////////////////////////////////////////////

  tcb_data_t          rdt_dly [TCB_DLY];
  logic [TCB_DLY-1:0] err_dly;

  // read data, zero when out of range
  always_ff @(posedge bus.clk) begin
    if (bus.trn && !bus.wen) begin
      rdt_dly[0] <= in_rng ? mem[idx] : '0;
    end
    for (int i = 1; i < TCB_DLY; i++) begin
      rdt_dly[i] <= rdt_dly[i-1];
    end
  end

  // error flag for reads and writes alike
  always_ff @(posedge bus.clk) begin
    if (bus.reset) begin
      err_dly <= '0;
    end else begin
      err_dly[0] <= bus.trn & ~in_rng;
      for (int i = 1; i < TCB_DLY; i++) begin
        err_dly[i] <= err_dly[i-1];
      end
    end
  end

  assign bus.rdt = rdt_dly[TCB_DLY-1].wrd;
  assign bus.err = err_dly[TCB_DLY-1];

  // a write with no byte enable would be a lost transfer
  a_wr_ben: assert property (@(posedge bus.clk) disable iff (bus.reset)
    (bus.trn && bus.wen) |-> (|bus.ben))
    else $error("write transfer without byte enable");

endmodule

// ==== verilog/tcb_arb.sv ====
`timescale 1ns/1ps

module tcb_arb
  import tcb_pkg::*;
(
  input logic bus,
  input logic reset,
  tcb_if.sub  man0,
  tcb_if.sub  man1,
  tcb_if.man  sub
);

  ////////////////////////////////////////////////////////////////////////////
  // round robin grant
  ////////////////////////////////////////////////////////////////////////////

  // index of the manager served last
  logic last;
  // selected manager where 1 means man1
  logic sel;

  // man1 wins alone or when man0 was served last
  always_comb begin
    sel = man1.vld & (~man0.vld | ~last);
  end

  // pointer moves only on a real transfer
  always_ff @(posedge bus) begin
    if (reset) begin
      // man0 favored out of reset
      last <= 1'b1;
    end else if (sub.trn) begin
      last <= sel;
    end
  end

  // request mux onto the subordinate
  always_comb begin
    sub.vld = man0.vld | man1.vld;
    if (sel) begin
      sub.wen = man1.wen;
      sub.adr = man1.adr;
      sub.ben = man1.ben;
      sub.wdt = man1.wdt;
    end else begin
      sub.wen = man0.wen;
      sub.adr = man0.adr;
      sub.ben = man0.ben;
      sub.wdt = man0.wdt;
    end
  end

  // loser sees rdy low and holds its request
  assign man0.rdy = sub.rdy & ~sel;
  assign man1.rdy = sub.rdy &  sel;

  ////////////////////////////////////////////////////////////////////////////
  // response routing
  ////////////////////////////////////////////////////////////////////////////

  // served index and transfer flag delayed to line up with the response
  logic [TCB_DLY-1:0] idx_dly;
  logic [TCB_DLY-1:0] vld_dly;
  logic               rsp_idx;
  logic               rsp_vld;

  always_ff @(posedge bus) begin
    if (reset) begin
      vld_dly <= '0;
    end else begin
      vld_dly[0] <= sub.trn;
      for (int i = 1; i < TCB_DLY; i++) begin
        vld_dly[i] <= vld_dly[i-1];
      end
    end
  end

  // index is payload qualified by vld_dly
  always_ff @(posedge bus) begin
    idx_dly[0] <= sel;
    for (int i = 1; i < TCB_DLY; i++) begin
      idx_dly[i] <= idx_dly[i-1];
    end
  end

  assign rsp_idx = idx_dly[TCB_DLY-1];
  assign rsp_vld = vld_dly[TCB_DLY-1];

  // steer the response and give the other manager zeros
  assign man0.rdt = (rsp_vld & ~rsp_idx) ? sub.rdt : '0;
  assign man1.rdt = (rsp_vld &  rsp_idx) ? sub.rdt : '0;
  assign man0.err = rsp_vld & ~rsp_idx & sub.err;
  assign man1.err = rsp_vld &  rsp_idx & sub.err;

  // after a transfer a contested cycle goes to the other manager
  a_rr_turn: assert property (@(posedge bus) disable iff (reset)
    sub.trn |=> (!(man0.vld && man1.vld && sub.rdy) || (man1.rdy != $past(sel))))
    else $error("round robin turn not taken");

endmodule

// ==== verilog/tcb_if.sv ====
`timescale 1ns/1ps

interface tcb_if
  import tcb_pkg::*;
(
  input logic clk,
  input logic reset
);

  // request, manager side
  logic              vld;
  logic              wen;
  logic [TCB_AW-1:0] adr;
  logic [TCB_BW-1:0] ben;
  logic [TCB_DW-1:0] wdt;

  // handshake and response, subordinate side
  logic              rdy;
  logic [TCB_DW-1:0] rdt;
  logic              err;

  // transfer on valid and ready together
  logic              trn;

  assign trn = vld & rdy;

  // manager drives the request
  modport man (
    input  clk, reset,
    output vld, wen, adr, ben, wdt,
    input  rdy, rdt, err,
    input  trn
  );

  // subordinate answers it
  modport sub (
    input  clk, reset,
    input  vld, wen, adr, ben, wdt,
    output rdy, rdt, err,
    input  trn
  );

endinterface

// ==== verilog/tcb_pkg.sv ====
package tcb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////////////////////

  // address width, byte addressing
  localparam int unsigned TCB_AW = 32;
  // data width
  localparam int unsigned TCB_DW = 32;
  // byte enables, one per data byte
  localparam int unsigned TCB_BW = TCB_DW / 8;

  // cycles from transfer edge to response
  localparam int unsigned TCB_DLY = 1;

  ////////////////////////////////////////////////////////////////////////////
  // memory geometry
  ////////////////////////////////////////////////////////////////////////////

  // words in the shared memory
  localparam int unsigned MEM_DEPTH = 256;
  // word index width
  localparam int unsigned MEM_AW = $clog2(MEM_DEPTH);

  ////////////////////////////////////////////////////////////////////////////
  // data word, two views
  ////////////////////////////////////////////////////////////////////////////

  // word view for ports, byte view for the byte enable merge
  typedef union packed {
    logic [TCB_DW-1:0]         wrd;
    logic [TCB_BW-1:0][8-1:0]  byt;
  } tcb_data_t;

endpackage
